// File: files.f
+incdir+sim
hdl/ccu_pkg.sv
hdl/ccu_cd_order_fifo.sv
hdl/ccu_cd_router.sv
hdl/ccu_collision_table.sv
hdl/ccu_ctrl_core.sv
sim/ccu_ctrl_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it
# Exit status is nonzero when the build or the simulation fails
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module ccu_ctrl_tb -f files.f -Mdir obj_dir &&
./obj_dir/Vccu_ctrl_tb ||
{ echo "build or simulation failed" >&2; exit 1; }

// File: sim/ccu_ctrl_tb_cases.svh
// Case tables of the CCU controller testbench
// Write-back jobs and collision table operations with expected results

`ifndef CCU_CTRL_TB_CASES_SVH
`define CCU_CTRL_TB_CASES_SVH

// Nibble i of beats is the beat count of port i
typedef struct packed {
    cd_user_e         user;
    logic [IDX_W-1:0] first;
    logic [3:0]       mask;
    logic [15:0]      beats;
    logic [3:0]       stall;
} job_row_t;

localparam logic [1:0] OP_LOOKUP = 2'd0;
localparam logic [1:0] OP_INSERT = 2'd1;
localparam logic [1:0] OP_REMOVE = 2'd2;

// exists is the lookup result and full the table state after the op
typedef struct packed {
    logic [1:0]  op;
    axi_id_t     id;
    logic [31:0] addr;
    logic        exists;
    logic        full;
} coll_row_t;

localparam int unsigned NUM_JOBS = 8;

// user, first responder, mask, beats per port 3..0, stall cycles
localparam job_row_t JOBS [NUM_JOBS] = '{
    '{MEMORY_UNIT, 2'd0, 4'b0001, 16'h0003, 4'd0},
    '{SNOOP_UNIT,  2'd2, 4'b0110, 16'h0420, 4'd2},
    '{MEMORY_UNIT, 2'd1, 4'b1011, 16'h3021, 4'd3},
    '{SNOOP_UNIT,  2'd3, 4'b1000, 16'h1000, 4'd1},
    '{SNOOP_UNIT,  2'd0, 4'b1111, 16'h2312, 4'd0},
    '{MEMORY_UNIT, 2'd2, 4'b0100, 16'h0500, 4'd4},
    '{MEMORY_UNIT, 2'd3, 4'b1100, 16'h1200, 4'd0},
    '{SNOOP_UNIT,  2'd1, 4'b0011, 16'h0024, 4'd2}
};

localparam int unsigned NUM_OPS = 17;

// op, id, byte address, exists, full after
localparam coll_row_t OPS [NUM_OPS] = '{
    '{OP_LOOKUP, 4'd0, 32'h1000_0040, 1'b0, 1'b0},
    '{OP_INSERT, 4'd3, 32'h1000_0040, 1'b0, 1'b0},
    '{OP_LOOKUP, 4'd0, 32'h1000_007f, 1'b1, 1'b0},
    '{OP_INSERT, 4'd3, 32'h2000_0100, 1'b0, 1'b0},
    '{OP_INSERT, 4'd5, 32'h3000_0000, 1'b0, 1'b0},
    '{OP_REMOVE, 4'd3, 32'h0000_0000, 1'b0, 1'b0},
    '{OP_LOOKUP, 4'd0, 32'h1000_0040, 1'b0, 1'b0},
    '{OP_LOOKUP, 4'd0, 32'h2000_0100, 1'b1, 1'b0},
    '{OP_INSERT, 4'd1, 32'h4000_0000, 1'b0, 1'b0},
    '{OP_INSERT, 4'd2, 32'h4000_0040, 1'b0, 1'b0},
    '{OP_INSERT, 4'd7, 32'h4000_0080, 1'b0, 1'b0},
    '{OP_INSERT, 4'd9, 32'h4000_00c0, 1'b0, 1'b1},
    '{OP_REMOVE, 4'd5, 32'h0000_0000, 1'b0, 1'b0},
    '{OP_INSERT, 4'd3, 32'h5000_0000, 1'b0, 1'b1},
    // Oldest entry of ID 3 goes while the newer one stays
    '{OP_REMOVE, 4'd3, 32'h0000_0000, 1'b0, 1'b0},
    '{OP_LOOKUP, 4'd0, 32'h2000_0100, 1'b0, 1'b0},
    '{OP_LOOKUP, 4'd0, 32'h5000_0000, 1'b1, 1'b0}
};

`endif

// File: sim/ccu_ctrl_tb.sv
// Testbench of the CCU controller core
// Write-back job routing and collision table checks from the case tables

`timescale 1ns/1ps

module ccu_ctrl_tb;

    import ccu_pkg::*;

    localparam int unsigned NO_MST_PORTS   = 4;
    localparam int unsigned ORDER_DEPTH    = 4;
    localparam int unsigned TABLE_CAPACITY = 6;
    localparam int unsigned IDX_W          = $clog2(NO_MST_PORTS);

    `include "ccu_ctrl_tb_cases.svh"

    logic                          clk_i;
    logic                          rst_ni;
    logic     [NO_MST_PORTS-1:0]   cd_valid_i;
    cd_beat_t [NO_MST_PORTS-1:0]   cd_beat_i;
    logic     [NO_MST_PORTS-1:0]   cd_ready_o;
    logic                          wb_push_i;
    cd_user_e                      wb_user_i;
    logic     [IDX_W-1:0]          wb_first_i;
    logic     [NO_MST_PORTS-1:0]   wb_avail_i;
    logic                          order_full_o;
    cd_beat_t                      mu_cd_o;
    logic                          mu_cd_valid_o;
    logic                          mu_full_i;
    cd_beat_t                      su_cd_o;
    logic                          su_cd_valid_o;
    logic                          su_full_i;
    logic                          lookup_i;
    line_addr_t                    lookup_addr_i;
    logic                          exists_o;
    logic                          insert_i;
    coll_entry_t                   insert_entry_i;
    logic                          remove_i;
    axi_id_t                       remove_id_i;
    logic                          table_full_o;

    logic [31:0]                   rng;
    logic [CD_DATA_WIDTH-1:0]      fwd_expect_q [$];
    int unsigned                   pending;
    logic                          full_exp;
    int unsigned                   cycle_cnt = 0;
    int unsigned                   cycle_limit;

    ccu_ctrl_core #(
        .NoMstPorts    (NO_MST_PORTS),
        .OrderDepth    (ORDER_DEPTH),
        .TableCapacity (TABLE_CAPACITY)
    ) UUT (.*);

    always #50 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout: run did not end within %0d cycles", cycle_limit);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    ////////////////////
    // Helpers
    ////////////////////

    task automatic compare_value(input logic [63:0] got, input logic [63:0] exp,
                                 input string what);
        if (got !== exp) begin
            $display("error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic int unsigned sum_beats();
        int unsigned sum;
        sum = 0;
        for (int j = 0; j < NUM_JOBS; j++) begin
            for (int i = 0; i < NO_MST_PORTS; i++) begin
                sum += 32'(JOBS[j].beats[4*i +: 4]);
            end
        end
        return sum;
    endfunction

    // Load a random beat on a port and queue it when it is forwarded
    task automatic load_beat(input int port, input int unsigned idx,
                             input int unsigned total, input logic track);
        logic [CD_DATA_WIDTH-1:0] data;
        rng = xorshift32(rng);
        data[63:32] = rng;
        rng = xorshift32(rng);
        data[31:0] = rng;
        cd_beat_i[port].data = data;
        cd_beat_i[port].last = (idx + 1 == total);
        cd_valid_i[port] = 1'b1;
        if (track) begin
            fwd_expect_q.push_back(data);
        end
    endtask

    task automatic push_job(input job_row_t job);
        wb_push_i  = 1'b1;
        wb_user_i  = job.user;
        wb_first_i = job.first;
        wb_avail_i = job.mask;
        @(negedge clk_i);
        compare_value(64'(order_full_o), 64'(pending == ORDER_DEPTH), "order_full at push");
        @(posedge clk_i);
        #10;
        wb_push_i = 1'b0;
        pending++;
    endtask

    // Drain all mask ports of the head job and follow the forwarded beats
    task automatic serve_job(input job_row_t job);
        int unsigned             sent [NO_MST_PORTS];
        int unsigned             total [NO_MST_PORTS];
        logic [NO_MST_PORTS-1:0] fin;
        logic [NO_MST_PORTS-1:0] exp_ready;
        logic [NO_MST_PORTS-1:0] hs;
        cd_beat_t                fwd;
        logic                    fwd_valid;
        int unsigned             cycle;
        int unsigned             nfwd;
        logic                    stall;
        logic                    job_end;
        cycle   = 0;
        nfwd    = 0;
        job_end = 1'b0;
        for (int i = 0; i < NO_MST_PORTS; i++) begin
            sent[i]  = 0;
            total[i] = 32'(job.beats[4*i +: 4]);
            fin[i]   = !job.mask[i];
            if (total[i] != 0) begin
                load_beat(i, 0, total[i], int'(job.first) == i);
            end
        end
        while (!job_end) begin
            stall     = (cycle < 32'(job.stall));
            mu_full_i = stall && (job.user == MEMORY_UNIT);
            su_full_i = stall && (job.user == SNOOP_UNIT);
            @(negedge clk_i);
            for (int i = 0; i < NO_MST_PORTS; i++) begin
                exp_ready[i] = job.mask[i] && !fin[i] && !(int'(job.first) == i && stall);
            end
            hs = cd_valid_i & exp_ready;
            compare_value(64'(cd_ready_o), 64'(exp_ready), "cd_ready");
            compare_value(64'(mu_cd_valid_o), 64'(hs[job.first] && job.user == MEMORY_UNIT),
                          "mu_cd_valid");
            compare_value(64'(su_cd_valid_o), 64'(hs[job.first] && job.user == SNOOP_UNIT),
                          "su_cd_valid");
            compare_value(64'(order_full_o), 64'(pending == ORDER_DEPTH), "order_full");
            fwd_valid = (job.user == MEMORY_UNIT) ? mu_cd_valid_o : su_cd_valid_o;
            if (fwd_valid) begin
                fwd = (job.user == MEMORY_UNIT) ? mu_cd_o : su_cd_o;
                compare_value(fwd.data, fwd_expect_q.pop_front(), "forwarded data");
                compare_value(64'(fwd.last), 64'(sent[job.first] + 1 == total[job.first]),
                              "forwarded last");
                nfwd++;
            end
            // Job pops at this edge once every mask port is done
            job_end = &fin;
            @(posedge clk_i);
            #10;
            for (int i = 0; i < NO_MST_PORTS; i++) begin
                if (hs[i]) begin
                    sent[i]++;
                    if (sent[i] == total[i]) begin
                        fin[i]        = 1'b1;
                        cd_valid_i[i] = 1'b0;
                    end else begin
                        load_beat(i, sent[i], total[i], int'(job.first) == i);
                    end
                end
            end
            cycle++;
        end
        mu_full_i = 1'b0;
        su_full_i = 1'b0;
        pending--;
        compare_value(64'(nfwd), 64'(total[job.first]), "forwarded beat count");
    endtask

    task automatic run_coll_op(input coll_row_t op);
        lookup_i            = (op.op == OP_LOOKUP);
        insert_i            = (op.op == OP_INSERT);
        remove_i            = (op.op == OP_REMOVE);
        lookup_addr_i       = op.addr[ADDR_WIDTH-1:LINE_OFFSET];
        insert_entry_i.id   = op.id;
        insert_entry_i.line = op.addr[ADDR_WIDTH-1:LINE_OFFSET];
        remove_id_i         = op.id;
        @(negedge clk_i);
        compare_value(64'(exists_o), 64'(op.exists), "exists");
        compare_value(64'(table_full_o), 64'(full_exp), "table_full");
        @(posedge clk_i);
        #10;
        lookup_i = 1'b0;
        insert_i = 1'b0;
        remove_i = 1'b0;
        full_exp = op.full;
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        clk_i          = 1'b0;
        rst_ni         = 1'b0;
        cd_valid_i     = '0;
        cd_beat_i      = '0;
        wb_push_i      = 1'b0;
        wb_user_i      = MEMORY_UNIT;
        wb_first_i     = '0;
        wb_avail_i     = '0;
        mu_full_i      = 1'b0;
        su_full_i      = 1'b0;
        lookup_i       = 1'b0;
        lookup_addr_i  = '0;
        insert_i       = 1'b0;
        insert_entry_i = '0;
        remove_i       = 1'b0;
        remove_id_i    = '0;
        rng            = 32'h5822_6c1f;
        pending        = 0;
        full_exp       = 1'b0;
        cycle_limit    = 4 * sum_beats() + 200;
        repeat (2) @(posedge clk_i);
        #10;
        rst_ni = 1'b1;
        @(negedge clk_i);
        compare_value(64'({cd_ready_o, mu_cd_valid_o, su_cd_valid_o, order_full_o,
                           exists_o, table_full_o}), 64'(0), "outputs after reset");
        @(posedge clk_i);
        #10;
        // Fill the order FIFO, then serve the group in push order
        for (int g = 0; g < NUM_JOBS; g += ORDER_DEPTH) begin
            for (int j = g; j < g + ORDER_DEPTH; j++) begin
                push_job(JOBS[j]);
            end
            for (int j = g; j < g + ORDER_DEPTH; j++) begin
                serve_job(JOBS[j]);
            end
        end
        for (int k = 0; k < NUM_OPS; k++) begin
            run_coll_op(OPS[k]);
        end
        @(negedge clk_i);
        compare_value(64'(table_full_o), 64'(full_exp), "table_full after last op");
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: hdl/ccu_ctrl_core.sv
// CCU controller core with snoop data routing and collision check

`timescale 1ns/1ps

module ccu_ctrl_core #(
    parameter int unsigned NoMstPorts    = 4,
    parameter int unsigned OrderDepth    = 4,
    parameter int unsigned TableCapacity = 6
) (
    input  logic                                    clk_i,
    input  logic                                    rst_ni,
    // Master port snoop data
    input  logic               [NoMstPorts-1:0]     cd_valid_i,
    input  ccu_pkg::cd_beat_t  [NoMstPorts-1:0]     cd_beat_i,
    output logic               [NoMstPorts-1:0]     cd_ready_o,
    // Write-back jobs
    input  logic                                    wb_push_i,
    input  ccu_pkg::cd_user_e                       wb_user_i,
    input  logic               [$clog2(NoMstPorts)-1:0] wb_first_i,
    input  logic               [NoMstPorts-1:0]     wb_avail_i,
    output logic                                    order_full_o,
    // Consumer units
    output ccu_pkg::cd_beat_t                       mu_cd_o,
    output logic                                    mu_cd_valid_o,
    input  logic                                    mu_full_i,
    output ccu_pkg::cd_beat_t                       su_cd_o,
    output logic                                    su_cd_valid_o,
    input  logic                                    su_full_i,
    // Collision check
    input  logic                                    lookup_i,
    input  ccu_pkg::line_addr_t                     lookup_addr_i,
    output logic                                    exists_o,
    input  logic                                    insert_i,
    input  ccu_pkg::coll_entry_t                    insert_entry_i,
    input  logic                                    remove_i,
    input  ccu_pkg::axi_id_t                        remove_id_i,
    output logic                                    table_full_o
);

    ccu_cd_router #(
        .NoMstPorts (NoMstPorts),
        .OrderDepth (OrderDepth)
    ) i_cd_router (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .cd_valid_i    (cd_valid_i),
        .cd_beat_i     (cd_beat_i),
        .cd_ready_o    (cd_ready_o),
        .wb_push_i     (wb_push_i),
        .wb_user_i     (wb_user_i),
        .wb_first_i    (wb_first_i),
        .wb_avail_i    (wb_avail_i),
        .order_full_o  (order_full_o),
        .mu_cd_o       (mu_cd_o),
        .mu_cd_valid_o (mu_cd_valid_o),
        .mu_full_i     (mu_full_i),
        .su_cd_o       (su_cd_o),
        .su_cd_valid_o (su_cd_valid_o),
        .su_full_i     (su_full_i)
    );

    ccu_collision_table #(
        .Capacity (TableCapacity)
    ) i_collision_table (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .lookup_i       (lookup_i),
        .lookup_addr_i  (lookup_addr_i),
        .exists_o       (exists_o),
        .insert_i       (insert_i),
        .insert_entry_i (insert_entry_i),
        .remove_i       (remove_i),
        .remove_id_i    (remove_id_i),
        .full_o         (table_full_o)
    );

endmodule

// File: hdl/ccu_collision_table.sv
// ID-tagged table of in-flight cache lines
// Lookup, insert into first free slot, remove oldest entry of an ID

`timescale 1ns/1ps

module ccu_collision_table #(
    parameter int unsigned Capacity = 6
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 lookup_i,
    input  ccu_pkg::line_addr_t  lookup_addr_i,
    output logic                 exists_o,
    input  logic                 insert_i,
    input  ccu_pkg::coll_entry_t insert_entry_i,
    input  logic                 remove_i,
    input  ccu_pkg::axi_id_t     remove_id_i,
    output logic                 full_o
);

    import ccu_pkg::*;

    localparam int unsigned CntWidth = $clog2(Capacity + 1);

    coll_entry_t           entry_q [Capacity];
    // Insertion order with 0 as the oldest valid entry
    logic [CntWidth-1:0]   age_q [Capacity];
    logic [Capacity-1:0]   valid_q;
    logic [CntWidth-1:0]   count_q;

    logic [Capacity-1:0]   hit;
    logic [Capacity-1:0]   id_match;
    logic                  ins_found;
    logic [CntWidth-1:0]   ins_idx;
    logic                  rem_found;
    logic [CntWidth-1:0]   rem_idx;
    logic [CntWidth-1:0]   rem_age;
    logic                  do_insert;
    logic                  do_remove;
    logic [CntWidth-1:0]   new_age;

    ////////////////////
    // Lookup
    ////////////////////

    for (genvar i = 0; i < Capacity; i++) begin : g_cmp
        assign hit[i]      = valid_q[i] && (entry_q[i].line == lookup_addr_i);
        assign id_match[i] = valid_q[i] && (entry_q[i].id == remove_id_i);
    end

    assign exists_o = lookup_i && |hit;
    assign full_o   = (count_q == CntWidth'(Capacity));

    // First free slot and oldest entry of the removed ID
    always_comb begin
        ins_found = 1'b0;
        ins_idx   = '0;
        rem_found = 1'b0;
        rem_idx   = '0;
        rem_age   = '0;
        for (int i = 0; i < Capacity; i++) begin
            if (!valid_q[i] && !ins_found) begin
                ins_found = 1'b1;
                ins_idx   = CntWidth'(i);
            end
            if (id_match[i] && (!rem_found || age_q[i] < rem_age)) begin
                rem_found = 1'b1;
                rem_idx   = CntWidth'(i);
                rem_age   = age_q[i];
            end
        end
    end

    assign do_insert = insert_i && ins_found;
    assign do_remove = remove_i && rem_found;
    assign new_age   = do_remove ? count_q - 1'b1 : count_q;

    ////////////////////
    // Update
    ////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            count_q <= '0;
        end else begin
            for (int i = 0; i < Capacity; i++) begin
                if (do_remove && rem_idx == CntWidth'(i)) begin
                    valid_q[i] <= 1'b0;
                end else if (do_insert && ins_idx == CntWidth'(i)) begin
                    valid_q[i] <= 1'b1;
                end
            end
            count_q <= count_q + CntWidth'(do_insert) - CntWidth'(do_remove);
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < Capacity; i++) begin
            if (do_insert && ins_idx == CntWidth'(i)) begin
                entry_q[i] <= insert_entry_i;
                age_q[i]   <= new_age;
            end else if (do_remove && valid_q[i] && age_q[i] > rem_age) begin
                // Close the gap left by the removed entry
                age_q[i] <= age_q[i] - 1'b1;
            end
        end
    end

    a_no_insert_full: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        insert_i |-> !full_o
    ) else $error("collision table insert while full");

    a_remove_present: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        remove_i |-> |id_match
    ) else $error("collision table remove of absent ID");

endmodule

// File: hdl/ccu_cd_router.sv
// Snoop data routing of write-back jobs
// Per-port last-beat tracking, CD ready and steering to the consumer units

`timescale 1ns/1ps

module ccu_cd_router #(
    parameter int unsigned NoMstPorts = 4,
    parameter int unsigned OrderDepth = 4
) (
    input  logic                                    clk_i,
    input  logic                                    rst_ni,
    // Snoop data from the master ports
    input  logic               [NoMstPorts-1:0]     cd_valid_i,
    input  ccu_pkg::cd_beat_t  [NoMstPorts-1:0]     cd_beat_i,
    output logic               [NoMstPorts-1:0]     cd_ready_o,
    // Write-back job push
    input  logic                                    wb_push_i,
    input  ccu_pkg::cd_user_e                       wb_user_i,
    input  logic               [$clog2(NoMstPorts)-1:0] wb_first_i,
    input  logic               [NoMstPorts-1:0]     wb_avail_i,
    output logic                                    order_full_o,
    // Consumer units
    output ccu_pkg::cd_beat_t                       mu_cd_o,
    output logic                                    mu_cd_valid_o,
    input  logic                                    mu_full_i,
    output ccu_pkg::cd_beat_t                       su_cd_o,
    output logic                                    su_cd_valid_o,
    input  logic                                    su_full_i
);

    import ccu_pkg::*;

    localparam int unsigned IdxWidth = $clog2(NoMstPorts);

    typedef struct packed {
        cd_user_e              user;
        logic [IdxWidth-1:0]   first;
        logic [NoMstPorts-1:0] avail;
    } job_t;

    job_t                  job_in;
    job_t                  job_head;
    logic                  job_empty;
    logic                  job_done;
    logic                  cons_full;
    logic [NoMstPorts-1:0] done_q;
    cd_beat_t              fwd_beat;
    logic                  fwd_hs;

    ////////////////////
    // Job order
    ////////////////////

    assign job_in.user  = wb_user_i;
    assign job_in.first = wb_first_i;
    assign job_in.avail = wb_avail_i;

    ccu_cd_order_fifo #(
        .DataWidth ($bits(job_t)),
        .Depth     (OrderDepth)
    ) i_order_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (wb_push_i),
        .data_i  (job_in),
        .pop_i   (job_done),
        .data_o  (job_head),
        .full_o  (order_full_o),
        .empty_o (job_empty)
    );

    // All ports of the mask have sent their last beat
    assign job_done = !job_empty && (done_q == job_head.avail);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            done_q <= '0;
        end else if (job_done) begin
            done_q <= '0;
        end else begin
            done_q <= done_q | (cd_valid_i & cd_ready_o & last_bits(cd_beat_i));
        end
    end

    function automatic logic [NoMstPorts-1:0] last_bits(input cd_beat_t [NoMstPorts-1:0] beats);
        logic [NoMstPorts-1:0] bits;
        for (int i = 0; i < NoMstPorts; i++) begin
            bits[i] = beats[i].last;
        end
        return bits;
    endfunction

    ////////////////////
    // Ready and steering
    ////////////////////

    assign cons_full = (job_head.user == MEMORY_UNIT) ? mu_full_i : su_full_i;

    for (genvar i = 0; i < NoMstPorts; i++) begin : g_ready
        // Back-pressure holds only the first responder
        assign cd_ready_o[i] = !job_empty && job_head.avail[i] && !done_q[i] &&
                               !(job_head.first == IdxWidth'(i) && cons_full);
    end

    assign fwd_beat = cd_beat_i[job_head.first];
    assign fwd_hs   = cd_valid_i[job_head.first] && cd_ready_o[job_head.first];

    assign mu_cd_o       = fwd_beat;
    assign su_cd_o       = fwd_beat;
    assign mu_cd_valid_o = fwd_hs && (job_head.user == MEMORY_UNIT);
    assign su_cd_valid_o = fwd_hs && (job_head.user == SNOOP_UNIT);

    a_no_push_full: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        wb_push_i |-> !order_full_o
    ) else $error("write-back job pushed while order FIFO full");

    a_strobe_needs_job: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (mu_cd_valid_o || su_cd_valid_o) |-> !job_empty
    ) else $error("consumer strobe without a pending job");

endmodule

// File: hdl/ccu_cd_order_fifo.sv
// Fall-through FIFO holding pending write-back jobs in order

`timescale 1ns/1ps

module ccu_cd_order_fifo #(
    parameter int unsigned DataWidth = 8,
    parameter int unsigned Depth     = 4
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 push_i,
    input  logic [DataWidth-1:0] data_i,
    input  logic                 pop_i,
    output logic [DataWidth-1:0] data_o,
    output logic                 full_o,
    output logic                 empty_o
);

    localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int unsigned CntWidth = $clog2(Depth + 1);

    logic [DataWidth-1:0] mem_q [Depth];
    logic [PtrWidth-1:0]  rd_ptr_q;
    logic [PtrWidth-1:0]  wr_ptr_q;
    logic [CntWidth-1:0]  count_q;
    logic                 stored_empty;
    logic                 push_mem;
    logic                 pop_mem;

    assign stored_empty = (count_q == '0);
    assign full_o       = (count_q == CntWidth'(Depth));
    assign empty_o      = stored_empty && !push_i;

    // Empty FIFO passes the incoming job straight through
    assign data_o = stored_empty ? data_i : mem_q[rd_ptr_q];

    // Job consumed in its push cycle never lands in memory
    assign push_mem = push_i && !full_o && !(stored_empty && pop_i);
    assign pop_mem  = pop_i && !stored_empty;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_mem) begin
                wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_mem) begin
                rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push_mem && !pop_mem) begin
                count_q <= count_q + 1'b1;
            end else if (pop_mem && !push_mem) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_mem) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    a_no_pop_empty: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        pop_i |-> !empty_o
    ) else $error("order FIFO popped while empty");

endmodule

// File: hdl/ccu_pkg.sv
// Shared widths and types of the CCU controller core
// Snoop data beat, write-back consumer and collision entry

package ccu_pkg;

    ////////////////////
    // Widths
    ////////////////////

    // Byte address as seen on the bus
    localparam int unsigned ADDR_WIDTH = 32;

    // 64-byte cache line
    localparam int unsigned LINE_OFFSET = 6;

    // Line part of a byte address
    localparam int unsigned LINE_ADDR_WIDTH = ADDR_WIDTH - LINE_OFFSET;

    // Transaction ID
    localparam int unsigned ID_WIDTH = 4;

    // One snoop data beat
    localparam int unsigned CD_DATA_WIDTH = 64;

    ////////////////////
    // Types
    ////////////////////

    typedef logic [LINE_ADDR_WIDTH-1:0] line_addr_t;

    typedef logic [ID_WIDTH-1:0] axi_id_t;

    // Unit that takes the data of a write-back job
    typedef enum logic {
        MEMORY_UNIT = 1'b0,
        SNOOP_UNIT  = 1'b1
    } cd_user_e;

    // Snoop data channel payload
    typedef struct packed {
        logic [CD_DATA_WIDTH-1:0] data;
        logic                     last;
    } cd_beat_t;

    // Outstanding transaction, tagged by ID
    typedef struct packed {
        axi_id_t    id;
        line_addr_t line;
    } coll_entry_t;

endpackage
